// File: dv/usbSieInput.txt
// Columns (hex): pid len d0 d1 d2 d3 flip bp keep, flip ff = no line bit inverted
// bp 1 = rx hold-off, bp 2 = tx underrun; pid 0 = bus reset row, len = SE0 cycles
3 03 01 02 03 00 ff 0 1
b 04 ff ff ff ff ff 0 1
3 00 00 00 00 00 ff 0 1
2 00 00 00 00 00 ff 0 1
1 02 81 3a 00 00 ff 0 1
d 02 00 10 00 00 ff 0 1
b 04 80 06 00 01 14 0 0
3 02 12 34 00 00 24 0 0
a 00 00 00 00 00 0a 0 0
3 03 11 22 33 00 ff 1 0
b 02 55 aa 00 00 ff 2 0
0 19 00 00 00 00 ff 0 1
0 0a 00 00 00 00 ff 0 0
b 01 7e 00 00 00 ff 0 1

// File: dv/usbSieTb.sv
`timescale 1ns/1ps

module usbSieTb;

    localparam int vecWords = 9;   // pid len d0..d3 flip bp keep
    localparam int maxVec   = 32;
    localparam int maxLine  = 256;

    logic       clk12_i = 1'b0;
    logic       reset_i, usbDp_i, usbDn_i, isSendingPhase_i, ackUsbResetDetect_i;
    logic       rxAcceptNewData_i, txReqSendPacket_i, txDataValid_i, txIsLastByte_i;
    logic [7:0] txData_i;
    logic       usbDp_o, usbDn_o, usbOe_o, usbResetDetected_o, txDoneSending_o;
    logic [7:0] rxData_o;
    logic       rxDataValid_o, rxDone_o, keepPacket_o, txAcceptNewData_o;

    logic [7:0] vecMem  [0:maxVec*vecWords-1];
    logic [1:0] lineBuf [0:maxLine-1];  // {dp, dn} per bit time
    logic [7:0] pktBytes [0:4];         // PID byte then payload
    logic [7:0] rxBytes [$];
    logic       rxKeep;
    int         pktLen, lineLen, doneCnt;
    int         errCnt, testErr, testCnt, failCnt;
    int         numVec, cycleCnt, cycleLimit;
    integer     seed;

    usbSie #(.resetCycles(20)) dut_i (
        .clk12_i, .reset_i, .usbDp_i, .usbDn_i, .usbDp_o, .usbDn_o, .usbOe_o,
        .isSendingPhase_i, .usbResetDetected_o, .ackUsbResetDetect_i, .txDoneSending_o,
        .rxAcceptNewData_i, .rxData_o, .rxDataValid_o, .rxDone_o, .keepPacket_o,
        .txReqSendPacket_i, .txDataValid_i, .txIsLastByte_i, .txData_i, .txAcceptNewData_o
    );

    always #5 clk12_i = ~clk12_i; // 10 ns bit time

    // Watchdog
    always @(posedge clk12_i) begin
        cycleCnt++;
        if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ==============================
    // Line recorder and done counter
    // ==============================
    always @(negedge clk12_i) begin
        if (usbOe_o && lineLen < maxLine) begin
            lineBuf[lineLen] = {usbDp_o, usbDn_o};
            lineLen++;
        end
        if (txDoneSending_o) begin
            doneCnt++;
            if (usbOe_o)
                reportError("txDoneSending_o while usbOe_o still high");
        end
    end

    task automatic reportError(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errCnt++;
        testErr++;
    endtask

    // Unchanged J/K level between bit times is an NRZI 1
    function automatic int longestOnesRun();
        int run;
        int longest;
        int i;
        run     = 0;
        longest = 0;
        for (i = 1; i < lineLen; i++) begin
            if (lineBuf[i] == 2'b00)
                break;                        // EOP reached
            run = (lineBuf[i] == lineBuf[i-1]) ? run + 1 : 0;
            if (run > longest)
                longest = run;
        end
        return longest;
    endfunction

    task automatic sendPacket(input bit underrun);
        int sent;
        lineLen = 0;
        doneCnt = 0;
        @(posedge clk12_i);
        isSendingPhase_i  <= 1'b1;
        txData_i          <= pktBytes[0];
        txIsLastByte_i    <= pktLen == 0;
        txDataValid_i     <= 1'b1;
        txReqSendPacket_i <= 1'b1;
        @(posedge clk12_i);
        txReqSendPacket_i <= 1'b0;
        @(negedge clk12_i);
        if (!usbOe_o)
            reportError("usbOe_o not high one cycle after txReqSendPacket_i");
        sent = 0;
        while (sent <= pktLen && !(underrun && sent == 1)) begin
            if (txAcceptNewData_o) begin
                @(posedge clk12_i);           // Byte taken on this edge
                sent++;
                if (underrun) begin
                    txDataValid_i <= 1'b0;    // Next request finds nothing
                end else if (sent <= pktLen) begin
                    txData_i       <= pktBytes[sent];
                    txIsLastByte_i <= sent == pktLen;
                end
            end
            @(negedge clk12_i);
        end
        @(posedge clk12_i);
        txDataValid_i <= 1'b0;
        @(negedge clk12_i);
        while (!txDoneSending_o)
            @(negedge clk12_i);
        @(posedge clk12_i);
        isSendingPhase_i <= 1'b0;             // Shared blocks back to rx
    endtask

    // Drive the recorded line back in, J and K swapped at flipIdx
    task automatic replayLine(input int flipIdx);
        int i;
        for (i = 0; i < lineLen; i++) begin
            @(posedge clk12_i);
            if (i == flipIdx)
                {usbDp_i, usbDn_i} <= ~lineBuf[i];
            else
                {usbDp_i, usbDn_i} <= lineBuf[i];
        end
        @(posedge clk12_i);
        {usbDp_i, usbDn_i} <= 2'b10;          // Idle J
    endtask

    task automatic drainRx(input bit holdOff);
        bit gotDone;
        bit holding;
        gotDone = 1'b0;
        holding = holdOff;
        rxBytes.delete();
        rxAcceptNewData_i <= !holdOff;
        while (!gotDone) begin
            @(negedge clk12_i);
            if (rxDataValid_o && rxAcceptNewData_i) begin
                rxBytes.push_back(rxData_o);  // Consumed on the next edge
                if (rxDone_o) begin
                    gotDone = 1'b1;
                    rxKeep  = keepPacket_o;
                end
            end else if (holding && rxDataValid_o) begin
                repeat (20) @(posedge clk12_i);
                rxAcceptNewData_i <= 1'b1;
                holding = 1'b0;
            end
        end
    endtask

    task automatic busResetTest(input int se0Cycles, input bit expectSet);
        @(posedge clk12_i);
        {usbDp_i, usbDn_i} <= 2'b00;
        repeat (se0Cycles) @(posedge clk12_i);
        {usbDp_i, usbDn_i} <= 2'b10;
        repeat (4) @(posedge clk12_i);        // Flag must hold without ack
        @(negedge clk12_i);
        if (usbResetDetected_o !== expectSet)
            reportError($sformatf("usbResetDetected_o=%b after %0d SE0 cycles, expected %b",
                usbResetDetected_o, se0Cycles, expectSet));
        @(posedge clk12_i);
        ackUsbResetDetect_i <= 1'b1;
        @(posedge clk12_i);
        ackUsbResetDetect_i <= 1'b0;
        @(negedge clk12_i);
        if (usbResetDetected_o !== 1'b0)
            reportError("usbResetDetected_o still high after ack with line at J");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int         base, len, flipIdx, bp, v, b;
        logic [7:0] pidWord;
        logic       expKeep;
        reset_i             = 1'b1;
        usbDp_i             = 1'b1;           // J
        usbDn_i             = 1'b0;
        isSendingPhase_i    = 1'b0;
        ackUsbResetDetect_i = 1'b0;
        rxAcceptNewData_i   = 1'b1;
        txReqSendPacket_i   = 1'b0;
        txDataValid_i       = 1'b0;
        txIsLastByte_i      = 1'b0;
        txData_i            = 8'h00;
        seed     = 32'h4f01;
        errCnt   = 0;
        testCnt  = 0;
        failCnt  = 0;
        cycleCnt = 0;
        lineLen  = 0;
        $readmemh("dv/usbSieInput.txt", vecMem);
        numVec = 0;
        while (numVec < maxVec && !$isunknown(vecMem[numVec*vecWords]))
            numVec++;
        cycleLimit = numVec * 400 + 200;
        repeat (3) @(posedge clk12_i);
        reset_i <= 1'b0;
        @(negedge clk12_i);
        if (usbOe_o || txAcceptNewData_o || txDoneSending_o || rxDataValid_o || rxDone_o ||
            usbResetDetected_o || {usbDp_o, usbDn_o} != 2'b10)
            reportError("outputs not idle after reset");
        if (numVec == 0) begin
            $display("No vectors could be read from dv/usbSieInput.txt");
            errCnt++;
        end

        for (v = 0; v < numVec; v++) begin
            base    = v * vecWords;
            pidWord = vecMem[base];
            len     = vecMem[base+1];
            flipIdx = (vecMem[base+6] == 8'hff) ? -1 : int'(vecMem[base+6]);
            bp      = vecMem[base+7];
            expKeep = vecMem[base+8][0];
            testErr = 0;
            if (pidWord == 8'h00) begin
                busResetTest(len, expKeep);
            end else begin
                pktBytes[0] = {~pidWord[3:0], pidWord[3:0]};
                for (b = 0; b < len; b++)
                    pktBytes[b+1] = vecMem[base+2+b];
                pktLen = len;
                sendPacket(bp == 2);
                if (lineLen < 11 || lineBuf[lineLen-1] != 2'b10 ||
                    lineBuf[lineLen-2] != 2'b00 || lineBuf[lineLen-3] != 2'b00)
                    reportError("packet does not end with two SE0 and one J");
                // Six 1s at most, the stuffed 0 breaks the run
                if (bp != 2 && longestOnesRun() > 6)
                    reportError($sformatf("%0d NRZI ones in a row on the line",
                        longestOnesRun()));
                fork
                    replayLine(flipIdx);
                    drainRx(bp == 1);
                join
                if (rxKeep !== expKeep)
                    reportError($sformatf("keepPacket_o=%b, expected %b", rxKeep, expKeep));
                if (flipIdx < 0 && bp == 0) begin
                    if (rxBytes.size() != len + 1)
                        reportError($sformatf("%0d bytes received, expected %0d",
                            rxBytes.size(), len + 1));
                    else
                        for (b = 0; b <= len; b++)
                            if (rxBytes[b] !== pktBytes[b])
                                reportError($sformatf("byte %0d is %h, expected %h",
                                    b, rxBytes[b], pktBytes[b]));
                end
                if (bp == 1 && (rxBytes.size() == 0 || rxBytes[0] !== pktBytes[0]))
                    reportError("first byte after overrun is not the PID");
                if (doneCnt != 1)
                    reportError($sformatf("%0d txDoneSending_o pulses", doneCnt));
            end
            testCnt++;
            if (testErr != 0)
                failCnt++;
            $display("test %0d pid %h: %s", v, pidWord[3:0], testErr == 0 ? "ok" : "mismatch");
            repeat (2 + $unsigned($random(seed)) % 6) @(posedge clk12_i); // Idle gap
        end

        $display("%0d tests, %0d failed, %0d errors", testCnt, failCnt, errCnt);
        if (errCnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: src/usbBitStuffer.sv
`timescale 1ns/1ps

module usbBitStuffer (
    input  logic                  clk12_i,
    input  logic                  reset_i,
    input  usbSiePkg::serialCtrlT ctrl_i,
    output logic                  stuffNow_o,   // Next bit is a stuffed zero
    output logic                  stuffError_o  // Seventh one seen
);

    logic [2:0] onesCnt;

    assign stuffNow_o   = onesCnt == 3'd6;
    assign stuffError_o = ctrl_i.stuffValid && ctrl_i.stuffBit && stuffNow_o;

    always_ff @(posedge clk12_i) begin
        if (reset_i || ctrl_i.stuffReset) begin
            onesCnt <= '0;
        end else if (ctrl_i.stuffValid) begin
            if (!ctrl_i.stuffBit)
                onesCnt <= '0;            // Any zero breaks the run
            else if (!stuffNow_o)
                onesCnt <= onesCnt + 3'd1; // Holds at six on error
        end
    end

    // Saturation keeps the run length bounded across packets
    assert property (@(posedge clk12_i) disable iff (reset_i) onesCnt <= 3'd6);

endmodule

// File: src/usbCrc16.sv
`timescale 1ns/1ps

module usbCrc16 (
    input  logic                  clk12_i,
    input  logic                  reset_i,
    input  usbSiePkg::serialCtrlT ctrl_i,
    output logic                  crcOk_o,
    output logic [15:0]           crc_o    // Inverted, bit 0 goes out first
);
    import usbSiePkg::*;

    logic [15:0] crcReg;
    logic        feedback;

    assign feedback = crcReg[15] ^ ctrl_i.crcBit;

    always_ff @(posedge clk12_i) begin
        if (reset_i || ctrl_i.crcReset)
            crcReg <= '1;
        else if (ctrl_i.crcValid)
            crcReg <= {crcReg[14:0], 1'b0} ^ ({16{feedback}} & CRC16_POLY);
    end

    assign crcOk_o = crcReg == CRC16_RESIDUAL;

    // Highest coefficient is sent first
    always_comb begin
        for (int i = 0; i < 16; i++)
            crc_o[i] = ~crcReg[15 - i];
    end

    // Rx and tx never preset and shift in the same bit time
    assert property (@(posedge clk12_i) disable iff (reset_i)
        !(ctrl_i.crcReset && ctrl_i.crcValid));

endmodule

// File: src/usbLineFrontend.sv
`timescale 1ns/1ps

module usbLineFrontend #(
    parameter int resetCycles = 30 // SE0 cycles that make a bus reset
) (
    input  logic                  clk12_i,
    input  logic                  reset_i,
    input  logic                  usbDp_i,
    input  logic                  usbDn_i,
    input  logic                  txBit_i,   // Raw bit, NRZI encoded here
    input  logic                  txDrive_i,
    input  logic                  txSe0_i,
    input  logic                  ackUsbReset_i,
    output logic                  usbDp_o,
    output logic                  usbDn_o,
    output logic                  usbOe_o,
    output logic                  rxBit_o,   // NRZI decoded bit
    output usbSiePkg::lineStateE  lineState_o,
    output logic                  eopDetected_o,
    output logic                  usbResetDetected_o
);
    import usbSiePkg::*;

    localparam int cntWidth = $clog2(resetCycles + 1);

    lineStateE            prevState;
    logic [cntWidth-1:0]  se0Cnt;
    logic                 outLevel;  // 1 = J
    logic                 nextLevel;

    // Receive side
    always_ff @(posedge clk12_i) begin
        if (reset_i) begin
            lineState_o <= J;
            prevState   <= J;
        end else begin
            lineState_o <= lineStateE'({usbDp_i, usbDn_i});
            prevState   <= lineState_o;
        end
    end

    assign rxBit_o       = lineState_o == prevState; // No transition means 1
    assign eopDetected_o = prevState == SE0 && lineState_o == J;

    // Bus reset: long SE0, sticky until acknowledged on a live line
    always_ff @(posedge clk12_i) begin
        if (reset_i) begin
            se0Cnt             <= '0;
            usbResetDetected_o <= 1'b0;
        end else begin
            if (lineState_o != SE0)
                se0Cnt <= '0;
            else if (se0Cnt != cntWidth'(resetCycles))
                se0Cnt <= se0Cnt + 1'b1; // Saturates
            if (lineState_o == SE0 && se0Cnt == cntWidth'(resetCycles - 1))
                usbResetDetected_o <= 1'b1;
            else if (ackUsbReset_i && lineState_o != SE0)
                usbResetDetected_o <= 1'b0;
        end
    end

    // Transmit side, a 0 toggles the level
    assign nextLevel = txBit_i ? outLevel : ~outLevel;
    assign usbOe_o   = txDrive_i;
    assign usbDp_o   = ~txSe0_i & nextLevel;
    assign usbDn_o   = ~txSe0_i & ~nextLevel;

    always_ff @(posedge clk12_i) begin
        if (reset_i)
            outLevel <= 1'b1;
        else if (!txDrive_i || txSe0_i)
            outLevel <= 1'b1; // Next packet starts from J
        else
            outLevel <= nextLevel;
    end

endmodule

// File: src/usbRx.sv
`timescale 1ns/1ps

module usbRx (
    input  logic                  clk12_i,
    input  logic                  reset_i,
    input  logic                  rxBit_i,
    input  usbSiePkg::lineStateE  lineState_i,
    input  logic                  eopDetected_i,
    input  logic                  crcOk_i,
    input  logic                  stuffNow_i,
    input  logic                  stuffError_i,
    input  logic                  rxAcceptNewData_i,
    output usbSiePkg::serialCtrlT ctrl_o,
    output logic [7:0]            rxData_o,
    output logic                  rxDataValid_o,
    output logic                  rxDone_o,
    output logic                  keepPacket_o
);
    import usbSiePkg::*;

    typedef enum logic [1:0] {stHunt, stPid, stData, stDone} stateE;

    stateE           state;
    logic [7:0]      shiftReg;
    logic [7:0]      newByte;
    logic [2:0]      bitCnt;
    logic [2:0][7:0] pipe;     // [0] newest, [2] three bytes back
    logic [1:0]      pipeCnt;
    logic            isData;
    logic            lineActive, bitValid, shiftIn, byteDone, syncMatch, eopNow;
    logic            pipeFull, present, overrun;
    logic [7:0]      outByte;

    assign lineActive = lineState_i == J || lineState_i == K;
    assign bitValid   = lineActive && !eopDetected_i;
    assign newByte    = {rxBit_i, shiftReg[7:1]};    // LSB first
    assign syncMatch  = state == stHunt && bitValid && newByte == SYNC_BYTE;
    assign shiftIn    = (state == stPid || state == stData) && bitValid && !stuffNow_i;
    assign byteDone   = shiftIn && bitCnt == 3'd7;
    assign eopNow     = (state == stPid || state == stData) && eopDetected_i;

    // Data packets withhold the two CRC bytes behind the last payload byte
    assign outByte  = isData ? pipe[2] : pipe[0];
    assign pipeFull = isData ? pipeCnt == 2'd3 : pipeCnt != 2'd0;
    assign present  = (byteDone && pipeFull) || eopNow;
    assign overrun  = present && rxDataValid_o && !rxAcceptNewData_i;

    always_comb begin
        ctrl_o.crcReset   = syncMatch;
        ctrl_o.crcValid   = shiftIn && state == stData && isData;
        ctrl_o.crcBit     = rxBit_i;
        ctrl_o.stuffReset = !lineActive;
        ctrl_o.stuffValid = bitValid;  // SYNC counts too, as on tx
        ctrl_o.stuffBit   = rxBit_i;
    end

    always_ff @(posedge clk12_i) begin
        if (reset_i) begin
            state         <= stHunt;
            shiftReg      <= '1;
            bitCnt        <= '0;
            pipeCnt       <= '0;
            isData        <= 1'b0;
            rxDataValid_o <= 1'b0;
            rxDone_o      <= 1'b0;
            keepPacket_o  <= 1'b1;
        end else begin
            if (rxAcceptNewData_i) begin // Byte consumed
                rxDataValid_o <= 1'b0;
                rxDone_o      <= 1'b0;
            end
            if (present) begin
                rxDone_o <= eopNow;
                if (overrun) begin
                    keepPacket_o <= 1'b0;  // Older byte stays
                end else begin
                    rxData_o      <= outByte;
                    rxDataValid_o <= 1'b1;
                end
            end

            case (state)
                stHunt: begin
                    if (bitValid)
                        shiftReg <= newByte;
                    if (syncMatch) begin
                        state        <= stPid;
                        bitCnt       <= '0;
                        pipeCnt      <= '0;
                        keepPacket_o <= 1'b1;
                    end
                end
                stPid, stData: begin
                    if (stuffError_i)
                        keepPacket_o <= 1'b0;
                    if (eopNow) begin
                        state <= stDone;
                        // Partial byte, short packet or bad CRC
                        if (bitCnt != 3'd0 || !pipeFull || (isData && !crcOk_i))
                            keepPacket_o <= 1'b0;
                    end else if (shiftIn) begin
                        shiftReg <= newByte;
                        bitCnt   <= bitCnt + 3'd1;
                        if (byteDone) begin
                            pipe <= {pipe[1:0], newByte};
                            if (!pipeFull)
                                pipeCnt <= pipeCnt + 2'd1;
                            if (state == stPid) begin
                                state  <= stData;
                                isData <= isDataPid(newByte[3:0]);
                                if (newByte[7:4] != ~newByte[3:0])
                                    keepPacket_o <= 1'b0; // PID check nibble
                            end
                        end
                    end
                end
                stDone: begin
                    // Wait until the last byte is taken
                    if (!rxDataValid_o || rxAcceptNewData_i) begin
                        state    <= stHunt;
                        shiftReg <= '1;
                    end
                end
                default: state <= stHunt;
            endcase
        end
    end

    assert property (@(posedge clk12_i) disable iff (reset_i) rxDone_o |-> rxDataValid_o);

endmodule

// File: src/usbSie.sv
`timescale 1ns/1ps

module usbSie #(
    parameter int resetCycles = 30 // 2.5 us of SE0
) (
    input  logic       clk12_i,             // One cycle per bit
    input  logic       reset_i,
    input  logic       usbDp_i,
    input  logic       usbDn_i,
    output logic       usbDp_o,
    output logic       usbDn_o,
    output logic       usbOe_o,
    input  logic       isSendingPhase_i,    // Selects tx for the shared blocks
    output logic       usbResetDetected_o,
    input  logic       ackUsbResetDetect_i,
    output logic       txDoneSending_o,
    input  logic       rxAcceptNewData_i,
    output logic [7:0] rxData_o,
    output logic       rxDataValid_o,
    output logic       rxDone_o,            // Byte on rxData_o is the last one
    output logic       keepPacket_o,        // Valid with rxDone_o
    input  logic       txReqSendPacket_i,
    input  logic       txDataValid_i,
    input  logic       txIsLastByte_i,      // Taken with txData_i
    input  logic [7:0] txData_i,            // PID first, CRC appended here
    output logic       txAcceptNewData_o
);
    import usbSiePkg::*;

    serialCtrlT  rxCtrl;
    serialCtrlT  txCtrl;
    serialCtrlT  sharedCtrl;
    lineStateE   lineState;
    logic        rxBit, eopDetected;
    logic        txBit, txDrive, txSe0;
    logic        crcOk, stuffNow, stuffError;
    logic [15:0] crc;

    usbLineFrontend #(.resetCycles(resetCycles)) frontend_i (
        .clk12_i, .reset_i, .usbDp_i, .usbDn_i,
        .txBit_i(txBit), .txDrive_i(txDrive), .txSe0_i(txSe0),
        .ackUsbReset_i(ackUsbResetDetect_i),
        .usbDp_o, .usbDn_o, .usbOe_o,
        .rxBit_o(rxBit), .lineState_o(lineState), .eopDetected_o(eopDetected),
        .usbResetDetected_o
    );

    // ==============================
    // Shared CRC and stuffer
    // ==============================
    assign sharedCtrl = isSendingPhase_i ? txCtrl : rxCtrl;

    usbCrc16 crc16_i (
        .clk12_i, .reset_i, .ctrl_i(sharedCtrl),
        .crcOk_o(crcOk), .crc_o(crc)
    );

    usbBitStuffer stuffer_i (
        .clk12_i, .reset_i, .ctrl_i(sharedCtrl),
        .stuffNow_o(stuffNow), .stuffError_o(stuffError)
    );
    // ==============================

    usbRx rx_i (
        .clk12_i, .reset_i,
        .rxBit_i(rxBit), .lineState_i(lineState), .eopDetected_i(eopDetected),
        .crcOk_i(crcOk), .stuffNow_i(stuffNow), .stuffError_i(stuffError),
        .rxAcceptNewData_i, .ctrl_o(rxCtrl),
        .rxData_o, .rxDataValid_o, .rxDone_o, .keepPacket_o
    );

    usbTx tx_i (
        .clk12_i, .reset_i,
        .txReqSendPacket_i, .txDataValid_i, .txIsLastByte_i, .txData_i,
        .crc_i(crc), .stuffNow_i(stuffNow), .ctrl_o(txCtrl),
        .txBit_o(txBit), .txDrive_o(txDrive), .txSe0_o(txSe0),
        .txAcceptNewData_o, .txDoneSending_o
    );

endmodule

// File: src/usbSiePkg.sv
package usbSiePkg;

    // ==============================
    // Packet identifiers
    // ==============================
    typedef enum logic [3:0] {
        OUT   = 4'b0001,
        IN    = 4'b1001,
        SETUP = 4'b1101,
        DATA0 = 4'b0011,
        DATA1 = 4'b1011,
        ACK   = 4'b0010,
        NAK   = 4'b1010,
        STALL = 4'b1110
    } pidE;

    // Encoded as {dp, dn} so the registered pins cast directly
    typedef enum logic [1:0] {
        SE0 = 2'b00,
        K   = 2'b01,
        J   = 2'b10,
        SE1 = 2'b11
    } lineStateE;

    // Serial controls toward the shared CRC and stuffer
    typedef struct packed {
        logic crcReset;   // Preset CRC register
        logic crcValid;   // Shift crcBit in
        logic crcBit;
        logic stuffReset; // Clear ones counter
        logic stuffValid; // Count stuffBit
        logic stuffBit;
    } serialCtrlT;

    localparam logic [15:0] CRC16_POLY     = 16'h8005; // x^16+x^15+x^2+1
    localparam logic [15:0] CRC16_RESIDUAL = 16'h800D; // Left over by a good packet
    localparam logic [7:0]  SYNC_BYTE      = 8'h80;    // KJKJKJKK on the line

    // Only data packets carry a CRC16
    function automatic logic isDataPid(logic [3:0] pid);
        return pidE'(pid) inside {DATA0, DATA1};
    endfunction

endpackage

// File: src/usbTx.sv
`timescale 1ns/1ps

module usbTx (
    input  logic                  clk12_i,
    input  logic                  reset_i,
    input  logic                  txReqSendPacket_i,
    input  logic                  txDataValid_i,
    input  logic                  txIsLastByte_i,
    input  logic [7:0]            txData_i,
    input  logic [15:0]           crc_i,     // Already inverted, send order
    input  logic                  stuffNow_i,
    output usbSiePkg::serialCtrlT ctrl_o,
    output logic                  txBit_o,
    output logic                  txDrive_o,
    output logic                  txSe0_o,
    output logic                  txAcceptNewData_o,
    output logic                  txDoneSending_o
);
    import usbSiePkg::*;

    typedef enum logic [2:0] {
        stIdle, stSync, stData, stCrc, stAbort, stEop, stDone
    } stateE;

    stateE      state;
    logic [7:0] txByte;
    logic [3:0] bitCnt;       // Up to 15 for the CRC
    logic [1:0] eopCnt;       // Two SE0 then one J
    logic       lastByte;
    logic       isData;
    logic       crcOn;        // Current byte goes into the CRC
    logic       stuffPending; // Run of six ends right before EOP

    assign stuffPending      = state == stEop && eopCnt == 2'd0 && stuffNow_i;
    assign txDrive_o         = !(state == stIdle || state == stDone);
    assign txSe0_o           = state == stEop && eopCnt != 2'd2 && !stuffPending;
    // Request while the last bit of the current byte is on the line
    assign txAcceptNewData_o = bitCnt == 4'd7 &&
        (state == stSync || (state == stData && !stuffNow_i && !lastByte));

    always_comb begin
        case (state)
            stSync:  txBit_o = SYNC_BYTE[bitCnt[2:0]];
            stData:  txBit_o = !stuffNow_i && txByte[bitCnt[2:0]];
            stCrc:   txBit_o = !stuffNow_i && crc_i[bitCnt];
            stEop:   txBit_o = !stuffPending;
            default: txBit_o = 1'b1; // Idle J, abort ones
        endcase
        ctrl_o.crcReset   = state == stSync;
        ctrl_o.crcValid   = state == stData && crcOn && !stuffNow_i;
        ctrl_o.crcBit     = txBit_o;
        ctrl_o.stuffReset = state inside {stIdle, stAbort, stDone};
        ctrl_o.stuffValid = state inside {stSync, stData, stCrc} || stuffPending;
        ctrl_o.stuffBit   = txBit_o;
    end

    always_ff @(posedge clk12_i) begin
        if (reset_i) begin
            state           <= stIdle;
            bitCnt          <= '0;
            eopCnt          <= '0;
            lastByte        <= 1'b0;
            isData          <= 1'b0;
            crcOn           <= 1'b0;
            txDoneSending_o <= 1'b0;
        end else begin
            txDoneSending_o <= state == stDone; // One cycle after Oe drops

            if (txAcceptNewData_o) begin
                bitCnt <= '0;
                if (txDataValid_i) begin
                    state    <= stData;
                    txByte   <= txData_i;
                    lastByte <= txIsLastByte_i;
                    crcOn    <= state == stData && isData; // PID is not covered
                    if (state == stSync)
                        isData <= isDataPid(txData_i[3:0]);
                end else begin
                    state <= stAbort; // Underrun
                end
            end else begin
                case (state)
                    stIdle: begin
                        bitCnt <= '0;
                        eopCnt <= '0;
                        if (txReqSendPacket_i)
                            state <= stSync;
                    end
                    stSync: bitCnt <= bitCnt + 4'd1;
                    stData: begin
                        if (!stuffNow_i) begin   // Counter waits on a stuffed zero
                            if (bitCnt == 4'd7) begin
                                bitCnt <= '0;
                                state  <= isData ? stCrc : stEop;
                            end else begin
                                bitCnt <= bitCnt + 4'd1;
                            end
                        end
                    end
                    stCrc: begin
                        if (!stuffNow_i) begin
                            if (bitCnt == 4'd15)
                                state <= stEop;
                            else
                                bitCnt <= bitCnt + 4'd1;
                        end
                    end
                    stAbort: begin
                        // Eight raw ones force a stuff error at the receiver
                        if (bitCnt == 4'd7)
                            state <= stEop;
                        else
                            bitCnt <= bitCnt + 4'd1;
                    end
                    stEop: begin
                        if (!stuffPending) begin
                            if (eopCnt == 2'd2)
                                state <= stDone;
                            else
                                eopCnt <= eopCnt + 2'd1;
                        end
                    end
                    stDone:  state <= stIdle;
                    default: state <= stIdle;
                endcase
            end
        end
    end

    assert property (@(posedge clk12_i) disable iff (reset_i) txSe0_o |-> txDrive_o);

endmodule

// File: usbSie.f
src/usbSiePkg.sv
src/usbLineFrontend.sv
src/usbCrc16.sv
src/usbBitStuffer.sv
src/usbRx.sv
src/usbTx.sv
src/usbSie.sv
dv/usbSieTb.sv
